/* hdl/sd_init_pkg.sv */
package sd_init_pkg;

  // --------------------------------------------------
  // basic types
  // --------------------------------------------------

  // one byte on the spi wires or on the status port
  typedef logic [7:0] sd_byte_t;

  // one entry of the init script, 10 bits wide
  typedef struct packed {
    // byte shifted out on mosi
    sd_byte_t data;
    // chip select level while this byte moves
    logic     cs_n;
    // forward the byte received in this slot to the status port
    logic     report;
  } init_step_t;

  // script length and index type
  localparam int SCRIPT_LEN = 78;
  typedef logic [6:0] step_idx_t;

  // divider counter width
  // msb is the wrap flag, so DIVIDER up to 255 fits
  localparam int DIVIDER_W = 9;

  // status markers, ascii "S" and "W"
  localparam sd_byte_t MARK_START = 8'h53;
  localparam sd_byte_t MARK_DONE  = 8'h57;

  // --------------------------------------------------
  // script building helpers
  // --------------------------------------------------

  // command byte, card selected, nothing reported
  function automatic init_step_t tx_step(input sd_byte_t b);
    tx_step = '{data: b, cs_n: 1'b0, report: 1'b0};
  endfunction

  // response slot, idle byte out, received byte reported
  // cs_n high gives the short deselect gaps in the acmd41 windows
  function automatic init_step_t rx_step(input logic cs_n);
    rx_step = '{data: 8'hFF, cs_n: cs_n, report: 1'b1};
  endfunction

  // power-up clocks with the card deselected
  localparam init_step_t PWR_STEP = '{data: 8'hFF, cs_n: 1'b1, report: 1'b0};

  // --------------------------------------------------
  // init script, walked in order by the sequencer
  // --------------------------------------------------
  localparam init_step_t INIT_SCRIPT [SCRIPT_LEN] = '{
    // 80 clocks with cs high and mosi high
    PWR_STEP, PWR_STEP, PWR_STEP, PWR_STEP, PWR_STEP,
    PWR_STEP, PWR_STEP, PWR_STEP, PWR_STEP, PWR_STEP,
    // cmd0 go idle, crc 0x95
    tx_step(8'h40), tx_step(8'h00), tx_step(8'h00),
    tx_step(8'h00), tx_step(8'h00), tx_step(8'h95),
    // cmd0 response window
    rx_step(1'b0), rx_step(1'b0), rx_step(1'b0),
    // cmd8 interface condition, arg 0x1AA, crc 0x87
    tx_step(8'h48), tx_step(8'h00), tx_step(8'h00),
    tx_step(8'h01), tx_step(8'hAA), tx_step(8'h87),
    // cmd8 response window, r7 is five bytes plus slack
    rx_step(1'b0), rx_step(1'b0), rx_step(1'b0), rx_step(1'b0),
    rx_step(1'b0), rx_step(1'b0), rx_step(1'b0),
    // cmd55, first round
    tx_step(8'h77), tx_step(8'h00), tx_step(8'h00),
    tx_step(8'h00), tx_step(8'h00), tx_step(8'hFF),
    // cmd55 response with a two byte deselect gap
    rx_step(1'b0), rx_step(1'b1), rx_step(1'b1), rx_step(1'b0),
    // acmd41 with hcs set
    tx_step(8'h69), tx_step(8'h40), tx_step(8'h00),
    tx_step(8'h00), tx_step(8'h00), tx_step(8'hFF),
    // acmd41 response window, two deselect gaps inside
    rx_step(1'b0), rx_step(1'b0), rx_step(1'b1), rx_step(1'b1),
    rx_step(1'b0), rx_step(1'b1), rx_step(1'b1), rx_step(1'b0),
    rx_step(1'b0), rx_step(1'b0), rx_step(1'b0),
    // cmd55, second round
    tx_step(8'h77), tx_step(8'h00), tx_step(8'h00),
    tx_step(8'h00), tx_step(8'h00), tx_step(8'hFF),
    // cmd55 response
    rx_step(1'b0), rx_step(1'b1), rx_step(1'b1), rx_step(1'b0),
    // acmd41 again
    tx_step(8'h69), tx_step(8'h40), tx_step(8'h00),
    tx_step(8'h00), tx_step(8'h00), tx_step(8'hFF),
    // short acmd41 window, last slot already deselected
    rx_step(1'b0), rx_step(1'b0), rx_step(1'b1)
  };

endpackage

/* hdl/spi_byte_if.sv */
`timescale 1ns/1ps

// byte handshake between the init sequencer and the spi byte engine
// w_stb only while w_ready is high and r_stb is low
interface spi_byte_if
  import sd_init_pkg::*;
();

  // start of one byte, single cycle
  logic     w_stb;
  // byte to send, taken with w_stb
  sd_byte_t w_data;
  // engine idle, drops the cycle after w_stb
  logic     w_ready;
  // byte finished, single cycle, w_ready rises with it
  logic     r_stb;
  // byte shifted in from miso, valid with r_stb
  sd_byte_t r_data;

  modport seq (output w_stb, output w_data, input w_ready, input r_stb, input r_data);

  modport eng (input w_stb, input w_data, output w_ready, output r_stb, output r_data);

endinterface

/* hdl/status_evt_if.sv */
`timescale 1ns/1ps

// status events from the sequencer to the reporter
// markers hold busy until acknowledged, response bytes never do
interface status_evt_if
  import sd_init_pkg::*;
();

  // one event per pulse, only while busy is low
  logic     evt_stb;
  // marker code or received byte
  sd_byte_t evt_data;
  // marker flag, valid with evt_stb
  logic     evt_marker;
  // a marker is still waiting for RES_ACK
  logic     busy;

  modport src (output evt_stb, output evt_data, output evt_marker, input busy);

  modport dst (input evt_stb, input evt_data, input evt_marker, output busy);

endinterface

/* hdl/spi_byte_engine.sv */
`timescale 1ns/1ps

// spi mode 0 byte engine
// one byte out on mosi and one byte in from miso per w_stb
module spi_byte_engine
  import sd_init_pkg::*;
#(
  parameter int DIVIDER = 5
) (
  input  logic   CLK,
  input  logic   RST,
  spi_byte_if.eng spi,
  output logic   MOSI,
  input  logic   MISO,
  output logic   SCLK
);

  // counter runs DIVIDER-2 down to all ones, so a wrap every DIVIDER cycles
  localparam logic [DIVIDER_W-1:0] DIV_RELOAD = DIVIDER_W'(DIVIDER - 2);

  logic [DIVIDER_W-1:0] div_cnt;
  logic                 tick;
  logic                 busy;
  logic [3:0]           edge_cnt;
  sd_byte_t             tx_shift;
  sd_byte_t             rx_shift;

  // --------------------------------------------------
  // sclk divider
  // --------------------------------------------------

  // wrap flag is the counter msb
  assign tick = div_cnt[DIVIDER_W-1];

  // held at reload while idle
  // first tick lands DIVIDER cycles after w_stb
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      div_cnt <= DIV_RELOAD;
    end else if (!busy || tick) begin
      div_cnt <= DIV_RELOAD;
    end else begin
      div_cnt <= div_cnt - 1'b1;
    end
  end

  // --------------------------------------------------
  // byte control
  // --------------------------------------------------

  // 16 ticks per byte, odd ticks rise and even ticks fall
  // r_stb follows the 16th tick, 16*DIVIDER+1 cycles after w_stb
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      SCLK      <= 1'b0;
      edge_cnt  <= 4'd0;
      spi.r_stb <= 1'b0;
    end else begin
      spi.r_stb <= 1'b0;
      if (!busy) begin
        // a strobe while busy is not accepted
        if (spi.w_stb) begin
          busy     <= 1'b1;
          edge_cnt <= 4'd0;
        end
      end else if (tick) begin
        SCLK     <= !SCLK;
        edge_cnt <= edge_cnt + 1'b1;
        // last falling edge leaves sclk low again
        if (edge_cnt == 4'd15) begin
          busy      <= 1'b0;
          spi.r_stb <= 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // shift registers
  // --------------------------------------------------

  // msb first
  // mosi moves on the falling edge, miso sampled on the rising edge
  always_ff @(posedge CLK) begin
    if (!busy && spi.w_stb) begin
      tx_shift <= spi.w_data;
    end else if (busy && tick) begin
      if (SCLK) begin
        tx_shift <= {tx_shift[6:0], 1'b1};
      end else begin
        rx_shift <= {rx_shift[6:0], MISO};
      end
    end
  end

  // idle line is high
  assign MOSI = busy ? tx_shift[7] : 1'b1;

  assign spi.w_ready = !busy;
  // no rising edge after the 8th bit, so the byte is stable at r_stb
  assign spi.r_data  = rx_shift;

endmodule

/* hdl/sd_init_sequencer.sv */
`timescale 1ns/1ps

// walks the init script one byte at a time
// drives chip select and raises marker and response events
module sd_init_sequencer
  import sd_init_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  spi_byte_if.seq    spi,
  status_evt_if.src  evt,
  output logic       CS
);

  typedef enum logic [1:0] {PH_START, PH_RUN, PH_DONE, PH_IDLE} phase_t;
  // gap keeps a last response pulse apart from the done marker
  typedef enum logic [1:0] {MK_GAP, MK_ISSUE, MK_WAIT} mark_t;

  phase_t     phase;
  mark_t      mark_st;
  step_idx_t  step;
  step_idx_t  next_step;
  init_step_t cur_step;
  logic       last_step;
  logic       in_marker;
  logic       mark_stb;
  logic       byte_stb;

  // --------------------------------------------------
  // script lookup and events
  // --------------------------------------------------
  assign cur_step  = INIT_SCRIPT[step];
  assign next_step = step + 1'b1;
  assign last_step = (step == step_idx_t'(SCRIPT_LEN - 1));
  assign in_marker = (phase == PH_START) || (phase == PH_DONE);

  // marker goes out once per marker phase, when the reporter is free
  assign mark_stb = in_marker && (mark_st == MK_ISSUE) && !evt.busy;
  // response byte straight off r_stb, reporter adds the one cycle
  assign byte_stb = (phase == PH_RUN) && spi.r_stb && cur_step.report;

  assign evt.evt_stb    = mark_stb || byte_stb;
  assign evt.evt_marker = mark_stb;
  assign evt.evt_data   = (phase == PH_START) ? MARK_START :
                          (phase == PH_DONE)  ? MARK_DONE  : spi.r_data;

  assign spi.w_data = cur_step.data;

  // --------------------------------------------------
  // phase FSM
  // --------------------------------------------------
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase     <= PH_START;
      mark_st   <= MK_ISSUE;
      step      <= '0;
      CS        <= 1'b1;
      spi.w_stb <= 1'b0;
    end else begin
      spi.w_stb <= 1'b0;
      case (phase)
        PH_START, PH_DONE: begin
          case (mark_st)
            MK_GAP:   mark_st <= MK_ISSUE;
            MK_ISSUE: if (!evt.busy) mark_st <= MK_WAIT;
            // busy is already up here, falls after RES_ACK
            default: begin
              if (!evt.busy) begin
                if (phase == PH_START) begin
                  phase <= PH_RUN;
                  step  <= '0;
                  CS    <= INIT_SCRIPT[0].cs_n;
                end else begin
                  phase <= PH_IDLE;
                end
              end
            end
          endcase
        end
        PH_RUN: begin
          // one strobe per idle period, never in the r_stb cycle
          spi.w_stb <= spi.w_ready && !spi.r_stb && !spi.w_stb;
          if (spi.r_stb) begin
            if (last_step) begin
              phase   <= PH_DONE;
              mark_st <= MK_GAP;
              CS      <= 1'b1;
            end else begin
              // cs follows the step index in the same cycle
              step <= next_step;
              CS   <= INIT_SCRIPT[next_step].cs_n;
            end
          end
        end
        default: CS <= 1'b1;
      endcase
    end
  end

endmodule

/* hdl/sd_status_reporter.sv */
`timescale 1ns/1ps

// status port driver
// markers wait for RES_ACK, response bytes are one cycle pulses
module sd_status_reporter
  import sd_init_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  status_evt_if.dst evt,
  output logic      RES_STB,
  output sd_byte_t  RES_DATA,
  input  logic      RES_ACK
);

  // marker on the port, not yet acknowledged
  logic mark_hold;

  // --------------------------------------------------
  // strobe and hold
  // --------------------------------------------------

  // one cycle from evt_stb to RES_STB
  // RES_ACK only matters while a marker is held
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      RES_STB   <= 1'b0;
      mark_hold <= 1'b0;
    end else begin
      if (evt.evt_stb) begin
        RES_STB   <= 1'b1;
        mark_hold <= evt.evt_marker;
      end else if (mark_hold) begin
        // drop in the cycle after the ack is seen
        if (RES_ACK) begin
          RES_STB   <= 1'b0;
          mark_hold <= 1'b0;
        end
      end else begin
        // response byte pulse ends here
        RES_STB <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // data
  // --------------------------------------------------

  // sequencer sends nothing while a marker is held
  // so RES_DATA stays put until the ack
  always_ff @(posedge CLK) begin
    if (evt.evt_stb) begin
      RES_DATA <= evt.evt_data;
    end
  end

  assign evt.busy = mark_hold;

endmodule

/* hdl/sd_init_top.sv */
`timescale 1ns/1ps

// sd card spi mode initializer
// reports "S", runs the init script, reports "W", then idles deselected
module sd_init_top
  import sd_init_pkg::*;
#(
  // sclk half period in CLK cycles, 2 to 255
  parameter int DIVIDER = 5
) (
  input  logic     CLK,
  input  logic     RST,
  // status port
  output logic     RES_STB,
  output sd_byte_t RES_DATA,
  input  logic     RES_ACK,
  // spi to the card
  output logic     MOSI,
  input  logic     MISO,
  output logic     SCLK,
  output logic     CS
);

  // --------------------------------------------------
  // internal links
  // --------------------------------------------------
  spi_byte_if   spi_link ();
  status_evt_if evt_link ();

  // --------------------------------------------------
  // blocks
  // --------------------------------------------------

  // script walker, owns chip select
  sd_init_sequencer i_sequencer (
    .CLK (CLK),
    .RST (RST),
    .spi (spi_link.seq),
    .evt (evt_link.src),
    .CS  (CS)
  );

  // sclk generation and byte shifting
  spi_byte_engine #(
    .DIVIDER (DIVIDER)
  ) i_engine (
    .CLK  (CLK),
    .RST  (RST),
    .spi  (spi_link.eng),
    .MOSI (MOSI),
    .MISO (MISO),
    .SCLK (SCLK)
  );

  // markers and response bytes onto the status port
  sd_status_reporter i_reporter (
    .CLK      (CLK),
    .RST      (RST),
    .evt      (evt_link.dst),
    .RES_STB  (RES_STB),
    .RES_DATA (RES_DATA),
    .RES_ACK  (RES_ACK)
  );

endmodule

/* verification/sd_card_model.sv */
`timescale 1ns/1ps

// spi mode 0 card model
// captures every mosi byte with the cs level at its first rising edge
// plays back miso bytes picked by play_idx from the testbench table
module sd_card_model
  import sd_init_pkg::*;
(
  input  logic      SCLK,
  input  logic      MOSI,
  input  logic      CS,
  output logic      MISO,
  // byte to return for the current slot
  input  sd_byte_t  resp_byte,
  // slot index that wraps at the script length so the table loops
  output step_idx_t play_idx
);

  localparam int LOG_DEPTH = 128;

  // capture logs read by the testbench after the run
  sd_byte_t    mosi_log [LOG_DEPTH];
  logic        cs_log   [LOG_DEPTH];
  int unsigned byte_cnt;

  logic [2:0]  bit_idx;
  sd_byte_t    shift_in;
  logic        cs_first;
  // guards against the x to 0 step of SCLK at reset
  logic        seen_rise;

  initial begin
    byte_cnt  = 0;
    bit_idx   = 3'd0;
    shift_in  = 8'h00;
    cs_first  = 1'b1;
    seen_rise = 1'b0;
  end

  // --------------------------------------------------
  // sclk edges
  // --------------------------------------------------
  always @(SCLK) begin
    if (SCLK === 1'b1) begin
      // rising edge samples mosi
      shift_in = {shift_in[6:0], MOSI};
      // cs of the byte is the level at its first edge
      if (bit_idx == 3'd0) begin
        cs_first = CS;
      end
      seen_rise = 1'b1;
    end else if (SCLK === 1'b0 && seen_rise) begin
      // falling edge moves on to the next bit
      seen_rise = 1'b0;
      if (bit_idx == 3'd7) begin
        if (byte_cnt < LOG_DEPTH) begin
          mosi_log[byte_cnt] = shift_in;
          cs_log[byte_cnt]   = cs_first;
        end
        byte_cnt = byte_cnt + 1;
        bit_idx  = 3'd0;
      end else begin
        bit_idx = bit_idx + 3'd1;
      end
    end
  end

  // msb first with the next bit set up after each falling edge
  assign MISO     = resp_byte[3'd7 - bit_idx];
  assign play_idx = step_idx_t'(byte_cnt % SCRIPT_LEN);

endmodule

/* verification/sd_init_tb.sv */
`timescale 1ns/1ps

// testbench for the sd card initializer
// the card model plays the step table and the status port is checked live
module sd_init_tb
  import sd_init_pkg::*;
();

  localparam int DIV = 3;
  // every byte with its gap plus both markers and some slack
  localparam int WATCH_CYCLES = SCRIPT_LEN * (16 * DIV + 4) + 2 * 8 + 200;

  // one row per script step
  typedef struct {
    sd_byte_t miso;
    sd_byte_t mosi;
    logic     cs;
    logic     report;
  } step_row_t;

  logic      CLK;
  logic      RST;
  logic      RES_STB;
  sd_byte_t  RES_DATA;
  logic      RES_ACK;
  logic      MOSI;
  logic      MISO;
  logic      SCLK;
  logic      CS;

  step_row_t rows [SCRIPT_LEN];
  sd_byte_t  card_resp;
  step_idx_t card_idx;

  int        seed = 80;
  int        mismatch_cnt = 0;
  int        fail_cnt = 0;
  logic      init_done = 1'b0;

  // --------------------------------------------------
  // DUT and card
  // --------------------------------------------------
  sd_init_top #(
    .DIVIDER (DIV)
  ) i_sd_init_top (
    .CLK      (CLK),
    .RST      (RST),
    .RES_STB  (RES_STB),
    .RES_DATA (RES_DATA),
    .RES_ACK  (RES_ACK),
    .MOSI     (MOSI),
    .MISO     (MISO),
    .SCLK     (SCLK),
    .CS       (CS)
  );

  sd_card_model i_card (
    .SCLK      (SCLK),
    .MOSI      (MOSI),
    .CS        (CS),
    .MISO      (MISO),
    .resp_byte (card_resp),
    .play_idx  (card_idx)
  );

  assign card_resp = rows[card_idx].miso;

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // --------------------------------------------------
  // compare tasks and helpers
  // --------------------------------------------------
  task automatic check_byte(input string name, input sd_byte_t got, input sd_byte_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s: got 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_counts();
    $display("error counts: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
  endtask

  // expected mosi, cs and report per step with distinct odd bytes for reported slots
  task automatic build_table();
    int k;
    k = 0;
    for (int i = 0; i < SCRIPT_LEN; i++) begin
      rows[i].mosi   = INIT_SCRIPT[i].data;
      rows[i].cs     = INIT_SCRIPT[i].cs_n;
      rows[i].report = INIT_SCRIPT[i].report;
      if (INIT_SCRIPT[i].report) begin
        rows[i].miso = sd_byte_t'(k * 8 + 1);
        k++;
      end else begin
        rows[i].miso = 8'hFF;
      end
    end
  endtask

  // response pulses ignore RES_ACK so it toggles at random meanwhile
  task automatic wait_response();
    do begin
      @(posedge CLK);
      RES_ACK <= ($random(seed) & 1) != 0;
      @(negedge CLK);
    end while (RES_STB !== 1'b1);
  endtask

  // marker must stay on the port until the ack is sampled
  task automatic ack_marker(input sd_byte_t mark, input string tag);
    int unsigned delay;
    do begin
      @(negedge CLK);
    end while (RES_STB !== 1'b1);
    check_byte({tag, " RES_DATA"}, RES_DATA, mark);
    delay = $unsigned($random(seed)) % 8;
    repeat (delay) begin
      @(negedge CLK);
      check_level({tag, " RES_STB held"}, RES_STB, 1'b1);
      check_byte({tag, " RES_DATA held"}, RES_DATA, mark);
    end
    @(posedge CLK);
    RES_ACK <= 1'b1;
    @(negedge CLK);
    check_level({tag, " RES_STB before ack"}, RES_STB, 1'b1);
    @(posedge CLK);
    RES_ACK <= 1'b0;
    @(negedge CLK);
    check_level({tag, " RES_STB after ack"}, RES_STB, 1'b0);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    RST     <= 1'b1;
    RES_ACK <= 1'b0;
    build_table();

    repeat (15) @(posedge CLK);
    @(negedge CLK);
    // idle levels while in reset
    check_level("CS in reset", CS, 1'b1);
    check_level("MOSI in reset", MOSI, 1'b1);
    check_level("SCLK in reset", SCLK, 1'b0);
    check_level("RES_STB in reset", RES_STB, 1'b0);
    @(posedge CLK);
    RST <= 1'b0;

    ack_marker(MARK_START, "start marker");

    // one pulse per reported step in table order
    for (int i = 0; i < SCRIPT_LEN; i++) begin
      if (rows[i].report) begin
        wait_response();
        check_byte($sformatf("RES_DATA step %0d", i), RES_DATA, rows[i].miso);
        @(negedge CLK);
        check_level($sformatf("RES_STB width step %0d", i), RES_STB, 1'b0);
      end
    end
    @(posedge CLK);
    RES_ACK <= 1'b0;

    ack_marker(MARK_DONE, "done marker");
    init_done = 1'b1;

    // deselected and silent for good
    repeat (200) begin
      @(negedge CLK);
      check_level("CS idle", CS, 1'b1);
      check_level("RES_STB idle", RES_STB, 1'b0);
    end

    if (i_card.byte_cnt != SCRIPT_LEN || i_card.bit_idx != 3'd0) begin
      fail_cnt++;
      $display("ERROR: card saw %0d bytes and %0d extra bits, expected exactly %0d bytes",
               i_card.byte_cnt, i_card.bit_idx, SCRIPT_LEN);
    end
    for (int i = 0; i < SCRIPT_LEN; i++) begin
      check_byte($sformatf("MOSI step %0d", i), i_card.mosi_log[i], rows[i].mosi);
      check_level($sformatf("CS step %0d", i), i_card.cs_log[i], rows[i].cs);
    end

    report_counts();
    if (mismatch_cnt + fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  initial begin : watchdog
    @(negedge RST);
    repeat (WATCH_CYCLES) @(posedge CLK);
    if (!init_done) begin
      fail_cnt++;
      $display("ERROR: timeout, the initializer did not finish within %0d cycles",
               WATCH_CYCLES);
      report_counts();
      $display("Some tests failed");
      $finish;
    end
  end

endmodule

/* project.f */
hdl/sd_init_pkg.sv
hdl/spi_byte_if.sv
hdl/status_evt_if.sv
hdl/spi_byte_engine.sv
hdl/sd_init_sequencer.sv
hdl/sd_status_reporter.sv
hdl/sd_init_top.sv
verification/sd_card_model.sv
verification/sd_init_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f project.f \
  --top-module sd_init_tb -Mdir obj_dir -o sd_init_sim \
  && out="$(./obj_dir/sd_init_sim)" \
  && echo "$out" \
  && echo "$out" | grep -q "All tests passed" \
  && exit 0 \
  || { echo "simulation did not pass"; exit 1; }
